//--- hdl/husky_macros.svh
`ifndef HUSKY_MACROS_SVH
`define HUSKY_MACROS_SVH

// Bus widths
`define HUSKY_DATA_W          8
`define HUSKY_ADDR_W          8
`define HUSKY_BLOCK_W         3
`define HUSKY_INDEX_W         5
`define HUSKY_BYTECNT_W       7

// Register block 1 answers to addresses 0x20 to 0x3F
`define HUSKY_REG_BLOCK       3'd1

// Register indices within the block
`define HUSKY_IDX_TARGET_CTRL 5'd0
`define HUSKY_IDX_STATUS      5'd1
`define HUSKY_IDX_SCRATCH     5'd2

`define HUSKY_SCRATCH_BYTES   4

// Heartbeat defaults, flash bit 22 gives a few Hz at the USB clock
`define HUSKY_HEARTBEAT_W     25
`define HUSKY_FLASH_BIT       22

`endif

//--- hdl/usb_bus_pkg.sv
`default_nettype none
`include "husky_macros.svh"

package usb_bus_pkg;

   // Byte position within a multi-byte register
   typedef logic [`HUSKY_BYTECNT_W-1:0] bytecnt_t;

   typedef struct packed {
      logic [`HUSKY_BLOCK_W-1:0] block;  // Upper bits select the register block
      logic [`HUSKY_INDEX_W-1:0] index;  // Register within the block
   } usb_addr_fields_t;

   // One address byte, seen raw by the bus and split by the decoders
   typedef union packed {
      logic [`HUSKY_ADDR_W-1:0] raw;
      usb_addr_fields_t         fields;
   } usb_addr_u;

endpackage

`default_nettype wire

//--- hdl/target_io_pkg.sv
`default_nettype none

package target_io_pkg;

   // Target control register, bit 0 is power_off
   typedef struct packed {
      logic pdic_val;
      logic pdic_oe;
      logic pdid_val;
      logic pdid_oe;
      logic nrst_val;
      logic nrst_oe;
      logic avrprog_en;
      logic power_off;
   } target_ctrl_t;

   // One resolved tri-state pin
   typedef struct packed {
      logic oe;   // Pin driven when set
      logic val;
   } pin_drive_t;

endpackage

`default_nettype wire

//--- hdl/usb_bus_capture.sv
`timescale 1ns/1ns
`default_nettype none
`include "husky_macros.svh"

module usb_bus_capture
   import usb_bus_pkg::*;
(
   input  wire                      clk_usb_buf,
   input  wire                      rst_n_i,
   input  wire usb_addr_u           usb_addr_i,
   input  wire [`HUSKY_DATA_W-1:0]  usb_data_i,
   input  wire                      usb_rdn_i,
   input  wire                      usb_wrn_i,
   input  wire                      usb_cen_n_i,
   input  wire                      usb_alen_n_i,
   input  wire [`HUSKY_DATA_W-1:0]  reg_rdata_i,
   output logic [`HUSKY_DATA_W-1:0] usb_data_o,
   output logic                     usb_data_oe_o,
   output usb_addr_u                reg_addr_o,
   output bytecnt_t                 reg_bytecnt_o,
   output logic [`HUSKY_DATA_W-1:0] reg_wdata_o,
   output logic                     reg_read_o,
   output logic                     reg_write_o
);

   logic                     rdn_q, rdn_qq;
   logic                     wrn_q, wrn_qq;
   logic                     cen_q;
   logic [`HUSKY_DATA_W-1:0] data_q;
   usb_addr_u                addr_q;
   bytecnt_t                 bytecnt_q;
   logic                     rd_hit_q;   // Last read was to our block
   logic                     rd_fall;
   logic                     wr_fall;
   logic                     block_hit;

   assign rd_fall   = rdn_qq & ~rdn_q & ~cen_q;
   assign wr_fall   = wrn_qq & ~wrn_q & ~cen_q;
   assign block_hit = (addr_q.fields.block == `HUSKY_REG_BLOCK);

   // Strobe sampling and address latch
   always_ff @(posedge clk_usb_buf) begin
      if (!rst_n_i) begin
         rdn_q         <= 1'b1;
         rdn_qq        <= 1'b1;
         wrn_q         <= 1'b1;
         wrn_qq        <= 1'b1;
         cen_q         <= 1'b1;
         usb_data_oe_o <= 1'b0;
         addr_q        <= '0;
         bytecnt_q     <= '0;
      end else begin
         rdn_q         <= usb_rdn_i;
         rdn_qq        <= rdn_q;
         wrn_q         <= usb_wrn_i;
         wrn_qq        <= wrn_q;
         cen_q         <= usb_cen_n_i;
         usb_data_oe_o <= ~usb_rdn_i & ~usb_cen_n_i;
         if (!usb_alen_n_i && !usb_cen_n_i) begin
            addr_q    <= usb_addr_i;
            bytecnt_q <= '0;
         end else if (rd_fall || wr_fall) begin
            bytecnt_q <= bytecnt_q + bytecnt_t'(1);  // Next byte of the register
         end
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      data_q <= usb_data_i;
      if (rd_fall || wr_fall) begin
         reg_addr_o    <= addr_q;
         reg_bytecnt_o <= bytecnt_q;
         reg_wdata_o   <= data_q;
      end
   end

   // One-cycle access pulses, gated to our block
   always_ff @(posedge clk_usb_buf) begin
      if (!rst_n_i) begin
         reg_read_o  <= 1'b0;
         reg_write_o <= 1'b0;
         rd_hit_q    <= 1'b0;
      end else begin
         reg_read_o  <= rd_fall & block_hit;
         reg_write_o <= wr_fall & block_hit;
         if (rd_fall)
            rd_hit_q <= block_hit;
      end
   end

   assign usb_data_o = rd_hit_q ? reg_rdata_i : '0;  // Other blocks read as zero

endmodule

`default_nettype wire

//--- hdl/husky_reg_bank.sv
`timescale 1ns/1ns
`default_nettype none
`include "husky_macros.svh"

module husky_reg_bank
   import usb_bus_pkg::*, target_io_pkg::*;
(
   input  wire                      clk_usb_buf,
   input  wire                      rst_n_i,
   input  wire usb_addr_u           reg_addr_i,
   input  wire bytecnt_t            reg_bytecnt_i,
   input  wire [`HUSKY_DATA_W-1:0]  reg_wdata_i,
   input  wire                      reg_read_i,
   input  wire                      reg_write_i,
   output logic [`HUSKY_DATA_W-1:0] reg_rdata_o,
   output target_ctrl_t             target_ctrl_o,
   output logic                     error_o
);

   localparam int SCR_SEL_W = $clog2(`HUSKY_SCRATCH_BYTES);

   logic [`HUSKY_DATA_W-1:0] scratch_q [`HUSKY_SCRATCH_BYTES];
   logic [`HUSKY_DATA_W-1:0] rdata_next;
   logic                     scr_in_range;
   logic [SCR_SEL_W-1:0]     scr_sel;

   assign scr_in_range = (reg_bytecnt_i < `HUSKY_SCRATCH_BYTES);
   assign scr_sel      = reg_bytecnt_i[SCR_SEL_W-1:0];

   always_ff @(posedge clk_usb_buf) begin
      if (!rst_n_i) begin
         target_ctrl_o <= '0;
         error_o       <= 1'b0;
         for (int i = 0; i < `HUSKY_SCRATCH_BYTES; i++)
            scratch_q[i] <= '0;
      end else if (reg_write_i) begin
         case (reg_addr_i.fields.index)
            `HUSKY_IDX_TARGET_CTRL: target_ctrl_o <= target_ctrl_t'(reg_wdata_i);
            `HUSKY_IDX_STATUS: begin
               if (reg_wdata_i[0])
                  error_o <= 1'b0;  // Write 1 to clear
            end
            `HUSKY_IDX_SCRATCH: begin
               if (scr_in_range)
                  scratch_q[scr_sel] <= reg_wdata_i;
            end
            default: error_o <= 1'b1;  // Sticky, undefined register
         endcase
      end
   end

   // Read mux
   always_comb begin
      rdata_next = '0;
      case (reg_addr_i.fields.index)
         `HUSKY_IDX_TARGET_CTRL: rdata_next = target_ctrl_o;
         `HUSKY_IDX_STATUS:      rdata_next = {{(`HUSKY_DATA_W-1){1'b0}}, error_o};
         `HUSKY_IDX_SCRATCH: begin
            if (scr_in_range)
               rdata_next = scratch_q[scr_sel];
         end
         default: rdata_next = '0;
      endcase
   end

   always_ff @(posedge clk_usb_buf) begin
      if (!rst_n_i)
         reg_rdata_o <= '0;
      else if (reg_read_i)
         reg_rdata_o <= rdata_next;  // Held until the next read
   end

endmodule

`default_nettype wire

//--- hdl/target_pin_drive.sv
`timescale 1ns/1ns
`default_nettype none

module target_pin_drive
   import target_io_pkg::*;
(
   input  wire target_ctrl_t target_ctrl_i,
   input  wire               sam_mosi_i,
   input  wire               sam_spck_i,
   input  wire               target_miso_i,
   output pin_drive_t        nrst_o,
   output pin_drive_t        pdid_o,
   output pin_drive_t        pdic_o,
   output pin_drive_t        mosi_o,
   output pin_drive_t        sck_o,
   output pin_drive_t        sam_miso_o,
   output logic              target_poweron_o
);

   // Power off releases everything, then AVR programming, then the manual enables
   always_comb begin
      nrst_o = '0;
      pdid_o = '0;
      pdic_o = '0;
      mosi_o = '0;
      sck_o  = '0;
      if (!target_ctrl_i.power_off) begin
         if (target_ctrl_i.avrprog_en) begin
            nrst_o = '{oe: 1'b1, val: 1'b0};  // Hold target in reset
            mosi_o = '{oe: 1'b1, val: sam_mosi_i};
            sck_o  = '{oe: 1'b1, val: sam_spck_i};
         end else begin
            nrst_o = '{oe: target_ctrl_i.nrst_oe, val: target_ctrl_i.nrst_val};
            pdid_o = '{oe: target_ctrl_i.pdid_oe, val: target_ctrl_i.pdid_val};
            pdic_o = '{oe: target_ctrl_i.pdic_oe, val: target_ctrl_i.pdic_val};
         end
      end
   end

   // MISO back to the SAM does not depend on target power
   assign sam_miso_o       = '{oe: target_ctrl_i.avrprog_en, val: target_miso_i};
   assign target_poweron_o = ~target_ctrl_i.power_off;

endmodule

`default_nettype wire

//--- hdl/status_leds.sv
`timescale 1ns/1ns
`default_nettype none
`include "husky_macros.svh"

module status_leds #(
   parameter int HEARTBEAT_W = `HUSKY_HEARTBEAT_W,
   parameter int FLASH_BIT   = `HUSKY_FLASH_BIT
) (
   input  wire  clk_usb_buf,
   input  wire  rst_n_i,
   input  wire  error_i,
   input  wire  pll_status_i,
   input  wire  glitch_led_i,
   output logic led_adc_o,
   output logic led_glitch_o
);

   logic [HEARTBEAT_W-1:0] heartbeat_q;

   always_ff @(posedge clk_usb_buf) begin
      if (!rst_n_i)
         heartbeat_q <= '0;
      else
         heartbeat_q <= heartbeat_q + 1'b1;
   end

   // Both LEDs flash together on an error
   assign led_adc_o    = error_i ? heartbeat_q[FLASH_BIT] : ~pll_status_i;
   assign led_glitch_o = error_i ? heartbeat_q[FLASH_BIT] : glitch_led_i;

endmodule

`default_nettype wire

//--- hdl/husky_ctrl_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "husky_macros.svh"

module husky_ctrl_top
   import usb_bus_pkg::*, target_io_pkg::*;
#(
   parameter int FLASH_BIT = `HUSKY_FLASH_BIT
) (
   input  wire                     clk_usb_buf,
   input  wire                     rst_n_i,
   input  wire usb_addr_u          usb_addr_i,
   input  wire [`HUSKY_DATA_W-1:0] usb_data_i,
   output wire [`HUSKY_DATA_W-1:0] usb_data_o,
   output wire                     usb_data_oe_o,
   input  wire                     usb_rdn_i,
   input  wire                     usb_wrn_i,
   input  wire                     usb_cen_n_i,
   input  wire                     usb_alen_n_i,
   input  wire                     sam_mosi_i,
   input  wire                     sam_spck_i,
   input  wire                     target_miso_i,
   output pin_drive_t              nrst_o,
   output pin_drive_t              pdid_o,
   output pin_drive_t              pdic_o,
   output pin_drive_t              mosi_o,
   output pin_drive_t              sck_o,
   output pin_drive_t              sam_miso_o,
   output wire                     target_poweron_o,
   input  wire                     glitch_led_i,
   input  wire                     pll_status_i,
   output wire                     led_adc_o,
   output wire                     led_glitch_o,
   input  wire                     trigger_i,
   output wire                     trig_out_o
);

   usb_addr_u                reg_addr;
   bytecnt_t                 reg_bytecnt;
   wire [`HUSKY_DATA_W-1:0]  reg_wdata;
   wire [`HUSKY_DATA_W-1:0]  reg_rdata;
   wire                      reg_read;
   wire                      reg_write;
   target_ctrl_t             target_ctrl;
   wire                      error_flag;

   usb_bus_capture i_usb_bus_capture (
      .clk_usb_buf   (clk_usb_buf),
      .rst_n_i       (rst_n_i),
      .usb_addr_i    (usb_addr_i),
      .usb_data_i    (usb_data_i),
      .usb_rdn_i     (usb_rdn_i),
      .usb_wrn_i     (usb_wrn_i),
      .usb_cen_n_i   (usb_cen_n_i),
      .usb_alen_n_i  (usb_alen_n_i),
      .reg_rdata_i   (reg_rdata),
      .usb_data_o    (usb_data_o),
      .usb_data_oe_o (usb_data_oe_o),
      .reg_addr_o    (reg_addr),
      .reg_bytecnt_o (reg_bytecnt),
      .reg_wdata_o   (reg_wdata),
      .reg_read_o    (reg_read),
      .reg_write_o   (reg_write)
   );

   husky_reg_bank i_husky_reg_bank (
      .clk_usb_buf   (clk_usb_buf),
      .rst_n_i       (rst_n_i),
      .reg_addr_i    (reg_addr),
      .reg_bytecnt_i (reg_bytecnt),
      .reg_wdata_i   (reg_wdata),
      .reg_read_i    (reg_read),
      .reg_write_i   (reg_write),
      .reg_rdata_o   (reg_rdata),
      .target_ctrl_o (target_ctrl),
      .error_o       (error_flag)
   );

   target_pin_drive i_target_pin_drive (
      .target_ctrl_i    (target_ctrl),
      .sam_mosi_i       (sam_mosi_i),
      .sam_spck_i       (sam_spck_i),
      .target_miso_i    (target_miso_i),
      .nrst_o           (nrst_o),
      .pdid_o           (pdid_o),
      .pdic_o           (pdic_o),
      .mosi_o           (mosi_o),
      .sck_o            (sck_o),
      .sam_miso_o       (sam_miso_o),
      .target_poweron_o (target_poweron_o)
   );

   status_leds #(
      .HEARTBEAT_W (`HUSKY_HEARTBEAT_W),
      .FLASH_BIT   (FLASH_BIT)
   ) i_status_leds (
      .clk_usb_buf  (clk_usb_buf),
      .rst_n_i      (rst_n_i),
      .error_i      (error_flag),
      .pll_status_i (pll_status_i),
      .glitch_led_i (glitch_led_i),
      .led_adc_o    (led_adc_o),
      .led_glitch_o (led_glitch_o)
   );

   assign trig_out_o = trigger_i;  // Straight to the trigger MCX

endmodule

`default_nettype wire

//--- verification/tb_husky_ctrl.sv
`timescale 1ns/1ns
`default_nettype none
`include "husky_macros.svh"

module tb_husky_ctrl
   import target_io_pkg::*;
;

   localparam int BUS_TIMEOUT = 20;
   localparam int LED_TIMEOUT = 40;  // Flash bit 4 toggles every 16 cycles
   localparam logic [7:0] ADDR_CTRL    = {`HUSKY_REG_BLOCK, `HUSKY_IDX_TARGET_CTRL};
   localparam logic [7:0] ADDR_STATUS  = {`HUSKY_REG_BLOCK, `HUSKY_IDX_STATUS};
   localparam logic [7:0] ADDR_SCRATCH = {`HUSKY_REG_BLOCK, `HUSKY_IDX_SCRATCH};
   localparam logic [7:0] ADDR_UNDEF   = {`HUSKY_REG_BLOCK, 5'd5};

   logic       clk_usb_buf = 1'b0;
   logic       rst_n;
   logic [7:0] usb_addr;
   logic [7:0] usb_data;
   wire  [7:0] usb_data_out;
   wire        usb_data_oe;
   logic       usb_rdn;
   logic       usb_wrn;
   logic       usb_cen_n;
   logic       usb_alen_n;
   logic       sam_mosi;
   logic       sam_spck;
   logic       target_miso;
   pin_drive_t nrst, pdid, pdic, mosi, sck, sam_miso;
   wire        target_poweron;
   logic       glitch_led;
   logic       pll_status;
   wire        led_adc;
   wire        led_glitch;
   logic       trigger;
   wire        trig_out;

   logic [31:0]  rng_state = 32'h5eea;
   target_ctrl_t shadow_ctrl;     // Last value written to TARGET_CTRL
   logic         pins_valid = 1'b0;

   always #20 clk_usb_buf = ~clk_usb_buf;

   husky_ctrl_top #(.FLASH_BIT(4)) i_dut (
      .clk_usb_buf      (clk_usb_buf),
      .rst_n_i          (rst_n),
      .usb_addr_i       (usb_addr),
      .usb_data_i       (usb_data),
      .usb_data_o       (usb_data_out),
      .usb_data_oe_o    (usb_data_oe),
      .usb_rdn_i        (usb_rdn),
      .usb_wrn_i        (usb_wrn),
      .usb_cen_n_i      (usb_cen_n),
      .usb_alen_n_i     (usb_alen_n),
      .sam_mosi_i       (sam_mosi),
      .sam_spck_i       (sam_spck),
      .target_miso_i    (target_miso),
      .nrst_o           (nrst),
      .pdid_o           (pdid),
      .pdic_o           (pdic),
      .mosi_o           (mosi),
      .sck_o            (sck),
      .sam_miso_o       (sam_miso),
      .target_poweron_o (target_poweron),
      .glitch_led_i     (glitch_led),
      .pll_status_i     (pll_status),
      .led_adc_o        (led_adc),
      .led_glitch_o     (led_glitch),
      .trigger_i        (trigger),
      .trig_out_o       (trig_out)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic next_rand(output logic [31:0] r);
      rng_state = xorshift32(rng_state);
      r = rng_state;
   endtask

   // Expected {poweron, nrst, pdid, pdic, mosi, sck, sam_miso}, each pin as {oe, val}
   function automatic logic [12:0] expected_pins(input target_ctrl_t c, input logic s_mosi,
                                                 input logic s_spck, input logic t_miso);
      logic [1:0] p_nrst, p_pdid, p_pdic, p_mosi, p_sck;
      p_nrst = 2'b00;
      p_pdid = 2'b00;
      p_pdic = 2'b00;
      p_mosi = 2'b00;
      p_sck  = 2'b00;
      if (!c.power_off && c.avrprog_en) begin
         p_nrst = 2'b10;              // Reset held low while programming
         p_mosi = {1'b1, s_mosi};
         p_sck  = {1'b1, s_spck};
      end else if (!c.power_off) begin
         p_nrst = {c.nrst_oe, c.nrst_val};
         p_pdid = {c.pdid_oe, c.pdid_val};
         p_pdic = {c.pdic_oe, c.pdic_val};
      end
      return {~c.power_off, p_nrst, p_pdid, p_pdic, p_mosi, p_sck, c.avrprog_en, t_miso};
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
         $display("TEST RESULT: FAIL");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   task automatic fail_timeout(input string what);
      $display("Timeout: %s", what);
      $display("TEST RESULT: FAIL");
      $fatal(1, "wait loop ran out of cycles");
   endtask

   task automatic latch_addr(input logic [7:0] a);
      @(posedge clk_usb_buf);
      usb_cen_n  <= 1'b0;
      usb_alen_n <= 1'b0;
      usb_addr   <= a;
      @(posedge clk_usb_buf);
      usb_alen_n <= 1'b1;
   endtask

   // Register takes the byte on the third edge after the strobe falls
   task automatic bus_write(input logic [7:0] d);
      @(posedge clk_usb_buf);
      usb_wrn  <= 1'b0;
      usb_data <= d;
      repeat (3) @(posedge clk_usb_buf);
      usb_wrn <= 1'b1;
      @(posedge clk_usb_buf);
   endtask

   task automatic bus_read(output logic [7:0] d);
      int n;
      @(posedge clk_usb_buf);
      usb_rdn <= 1'b0;
      n = 0;
      do begin
         @(negedge clk_usb_buf);
         n++;
         if (n > BUS_TIMEOUT)
            fail_timeout("usb_data_oe_o never rose during a read");
      end while (usb_data_oe !== 1'b1);
      repeat (2) @(posedge clk_usb_buf);  // Bank pulse, then read data
      @(negedge clk_usb_buf);
      d = usb_data_out;
      @(posedge clk_usb_buf);
      usb_rdn <= 1'b1;
      n = 0;
      do begin
         @(negedge clk_usb_buf);
         n++;
         if (n > BUS_TIMEOUT)
            fail_timeout("usb_data_oe_o stayed high after the read ended");
      end while (usb_data_oe !== 1'b0);
      @(posedge clk_usb_buf);
   endtask

   task automatic wait_led_toggle();
      logic start;
      int   n;
      @(negedge clk_usb_buf);
      start = led_adc;
      n = 0;
      do begin
         @(negedge clk_usb_buf);
         n++;
         if (n > LED_TIMEOUT)
            fail_timeout("led_adc_o did not flash while the error was set");
      end while (led_adc === start);
   endtask

   // Pins follow the reference rule at every cycle once a control value is known
   always @(negedge clk_usb_buf) begin : compare_pins
      logic [12:0] exp_pins;
      if (pins_valid) begin
         exp_pins = expected_pins(shadow_ctrl, sam_mosi, sam_spck, target_miso);
         check_value("target_poweron_o", target_poweron, exp_pins[12]);
         check_value("nrst_o", nrst, exp_pins[11:10]);
         check_value("pdid_o", pdid, exp_pins[9:8]);
         check_value("pdic_o", pdic, exp_pins[7:6]);
         check_value("mosi_o", mosi, exp_pins[5:4]);
         check_value("sck_o", sck, exp_pins[3:2]);
         check_value("sam_miso_o", sam_miso, exp_pins[1:0]);
      end
   end

   initial begin : test_sequence
      logic [7:0]  rd_val;
      logic [7:0]  scratch_exp [`HUSKY_SCRATCH_BYTES];
      logic [31:0] r;
      rst_n       = 1'b0;
      usb_addr    = '0;
      usb_data    = '0;
      usb_rdn     = 1'b1;
      usb_wrn     = 1'b1;
      usb_cen_n   = 1'b1;
      usb_alen_n  = 1'b1;
      sam_mosi    = 1'b0;
      sam_spck    = 1'b0;
      target_miso = 1'b0;
      glitch_led  = 1'b1;
      pll_status  = 1'b1;
      trigger     = 1'b0;
      repeat (16) @(posedge clk_usb_buf);
      rst_n <= 1'b1;
      @(negedge clk_usb_buf);

      // Reset state
      check_value("usb_data_oe_o", usb_data_oe, 1'b0);
      check_value("nrst_o.oe", nrst.oe, 1'b0);
      check_value("pdid_o.oe", pdid.oe, 1'b0);
      check_value("pdic_o.oe", pdic.oe, 1'b0);
      check_value("mosi_o.oe", mosi.oe, 1'b0);
      check_value("sck_o.oe", sck.oe, 1'b0);
      check_value("sam_miso_o.oe", sam_miso.oe, 1'b0);
      check_value("target_poweron_o", target_poweron, 1'b1);
      check_value("led_adc_o", led_adc, !pll_status);
      shadow_ctrl = '0;
      pins_valid  = 1'b1;

      for (int i = 0; i < 20; i++) begin
         @(posedge clk_usb_buf);
         next_rand(r);
         sam_mosi    <= r[8];
         sam_spck    <= r[9];
         target_miso <= r[10];
         pins_valid = 1'b0;
         latch_addr(ADDR_CTRL);
         bus_write(r[7:0]);
         shadow_ctrl = target_ctrl_t'(r[7:0]);
         pins_valid  = 1'b1;
         latch_addr(ADDR_CTRL);
         bus_read(rd_val);
         check_value("TARGET_CTRL", rd_val, r[7:0]);
      end

      // Scratch bytes stepped by the byte count
      latch_addr(ADDR_SCRATCH);
      for (int i = 0; i < `HUSKY_SCRATCH_BYTES; i++) begin
         next_rand(r);
         scratch_exp[i] = r[7:0];
         bus_write(r[7:0]);
      end
      latch_addr(ADDR_SCRATCH);
      for (int i = 0; i < `HUSKY_SCRATCH_BYTES; i++) begin
         bus_read(rd_val);
         check_value("SCRATCH", rd_val, scratch_exp[i]);
      end
      bus_read(rd_val);
      check_value("SCRATCH past last byte", rd_val, 8'h00);

      latch_addr(ADDR_UNDEF);
      bus_write(8'h5a);
      latch_addr(ADDR_STATUS);
      bus_read(rd_val);
      check_value("STATUS", rd_val, 8'h01);
      wait_led_toggle();
      check_value("led_glitch_o", led_glitch, led_adc);
      wait_led_toggle();
      latch_addr(ADDR_STATUS);
      bus_write(8'h01);
      @(negedge clk_usb_buf);
      check_value("led_adc_o", led_adc, !pll_status);
      check_value("led_glitch_o", led_glitch, glitch_led);
      latch_addr(ADDR_STATUS);
      bus_read(rd_val);
      check_value("STATUS", rd_val, 8'h00);

      // Block 0 is somebody else's
      latch_addr(8'h00);
      bus_write(~shadow_ctrl);
      latch_addr(8'h02);
      bus_write(~scratch_exp[0]);
      latch_addr(8'h05);
      bus_write(8'hff);
      latch_addr(8'h00);
      bus_read(rd_val);
      check_value("usb_data_o block 0", rd_val, 8'h00);
      latch_addr(ADDR_CTRL);
      bus_read(rd_val);
      check_value("TARGET_CTRL", rd_val, shadow_ctrl);
      latch_addr(ADDR_SCRATCH);
      bus_read(rd_val);
      check_value("SCRATCH", rd_val, scratch_exp[0]);
      latch_addr(ADDR_STATUS);
      bus_read(rd_val);
      check_value("STATUS", rd_val, 8'h00);

      // Trigger alternates so both levels pass through
      for (int i = 0; i < 6; i++) begin
         @(posedge clk_usb_buf);
         trigger <= ~trigger;
         @(negedge clk_usb_buf);
         check_value("trig_out_o", trig_out, trigger);
      end

      repeat (4) @(posedge clk_usb_buf);
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+hdl
hdl/usb_bus_pkg.sv
hdl/target_io_pkg.sv
hdl/usb_bus_capture.sv
hdl/husky_reg_bank.sv
hdl/target_pin_drive.sv
hdl/status_leds.sv
hdl/husky_ctrl_top.sv
verification/tb_husky_ctrl.sv

//--- Bender.yml
package:
  name: husky_ctrl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/usb_bus_pkg.sv
      - hdl/target_io_pkg.sv
      - hdl/usb_bus_capture.sv
      - hdl/husky_reg_bank.sv
      - hdl/target_pin_drive.sv
      - hdl/status_leds.sv
      - hdl/husky_ctrl_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verification/tb_husky_ctrl.sv
